//--- filelist.f
verilog/lb_pkg.sv
verilog/demo_regs_pkg.sv
verilog/freq_count.sv
verilog/lb_arbiter.sv
verilog/lb_demo_slave.sv
verilog/lb_demo_top.sv
verification/lb_arbiter_sva.sv
verification/lb_demo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := lb_demo_tb
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINT      := --lint-only -Wall --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/lb_demo_tb.sv
// Testbench for the demo local bus block
// Runs a table of accesses on both master ports, then checks the fault count,
// the LEDs and PWM duty, the frequency counter and the arbitration order
`timescale 1ns/1ps

module lb_demo_tb;
	import lb_pkg::*;
	import demo_regs_pkg::*;

	// One stimulus row, reads compare rdata with exp
	typedef struct packed {
		logic     port;  // 0 host, 1 debug
		logic     rd;
		lb_addr_t addr;
		lb_data_t wdata;
		lb_data_t exp;
	} row_t;

	localparam int TABLE_ROWS = 24;
	localparam int WINDOW = 256;  // 2^8 clk cycles
	localparam int FREQ_EXP = WINDOW / 4;  // f_in period is 4 clk cycles
	localparam int PWM_PERIOD = 1 << PWM_CNT_WIDTH;
	localparam int ACCESS_MAX = 16;
	localparam int TIMEOUT_CYCLES = 5 + (TABLE_ROWS + 12) * ACCESS_MAX + 2 * 32
		+ PWM_PERIOD + 2 * WINDOW + 500;

	logic clk;
	logic rst_n;
	logic host_req;
	lb_req_t host_txn;
	logic host_ack;
	lb_data_t host_rdata;
	logic dbg_req;
	lb_req_t dbg_txn;
	logic dbg_ack;
	lb_data_t dbg_rdata;
	logic f_in = 1'b0;
	logic f_half = 1'b0;
	logic f_run;
	logic xdomain_fault;
	logic led_user_mode;
	logic led1;
	logic led2;
	int cycle = 0;
	int errors = 0;
	int checks = 0;
	logic [7:0] lfsr_state;
	row_t table_rows [TABLE_ROWS];

	lb_demo_top #(.REFCNT_WIDTH(8), .FREQ_WIDTH(32)) u_dut (
		.clk(clk), .rst_n(rst_n),
		.host_req(host_req), .host_txn(host_txn), .host_ack(host_ack), .host_rdata(host_rdata),
		.dbg_req(dbg_req), .dbg_txn(dbg_txn), .dbg_ack(dbg_ack), .dbg_rdata(dbg_rdata),
		.f_in(f_in), .xdomain_fault(xdomain_fault),
		.led_user_mode(led_user_mode), .led1(led1), .led2(led2)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// External clock, toggles every second clk cycle once enabled
	always begin
		@(posedge clk);
		#2;
		if (f_run) begin
			f_half = ~f_half;
			if (!f_half)
				f_in = ~f_in;
		end
	end

	// Run limit, a stuck handshake ends here
	initial begin
		while (cycle < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("Timeout after %0d cycles, a bus access never completed", cycle);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// One step per bit taken
	function logic [7:0] take_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic lb_addr_t reg_addr(input logic [7:0] bank, input logic [3:0] ofs);
		return {bank, 12'h000, ofs};
	endfunction

	function automatic row_t make_row(input logic port, input logic rd, input lb_addr_t a,
			input lb_data_t wd, input lb_data_t exp);
		return '{port, rd, a, wd, exp};
	endfunction

	task automatic fill_table();
		lb_data_t id_words [4];
		id_words = '{ID_WORD0, ID_WORD1, ID_WORD2, ID_WORD3};
		// ID string from both ports
		for (int i = 0; i < 8; i++)
			table_rows[i] = make_row(1'(i / 4), 1'b1, reg_addr(BANK_REGS, 4'(i % 4)), '0,
				id_words[i % 4]);
		// Offsets past the frequency register
		for (int i = 6; i < 16; i++)
			table_rows[i + 2] = make_row(1'(i % 2), 1'b1, reg_addr(BANK_REGS, 4'(i)), '0,
				UNUSED_OFS_WORD);
		table_rows[18] = make_row(1'b0, 1'b1, reg_addr(BANK_BADGE_IN, 4'd0), '0, BADGE_WORD);
		table_rows[19] = make_row(1'b1, 1'b1, reg_addr(BANK_BADGE_OUT, 4'd3), '0, BADGE_WORD);
		table_rows[20] = make_row(1'b0, 1'b1, reg_addr(8'h00, 4'd0), '0, UNMAPPED_WORD);
		table_rows[21] = make_row(1'b1, 1'b1, reg_addr(8'h12, 4'd5), '0, UNMAPPED_WORD);
		table_rows[22] = make_row(1'b0, 1'b1, reg_addr(8'hff, 4'd1), '0, UNMAPPED_WORD);
		// User LED on, checked after the loop
		table_rows[23] = make_row(1'b1, 1'b0, reg_addr(BANK_REGS, OFS_LED_USER), 32'h1, '0);
	endtask

	task automatic check_word(input string what, input lb_data_t got, input lb_data_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_order(input string what, input int first, input int second);
		checks++;
		assert (first < second) else begin
			errors++;
			$display("Error at %0d ns: %s came in the wrong order (cycle %0d, then %0d)",
				$time, what, first, second);
		end
	endtask

	// Four-phase access, req held for hold extra cycles after ack
	task automatic bus_access(input logic port, input logic rd, input lb_addr_t a,
			input lb_data_t wd, input int hold, output lb_data_t rdata,
			output int ack_cyc, output int drop_cyc);
		lb_req_t t;
		t = '{rd, a, wd};
		@(posedge clk);
		#2;
		if (port) begin
			dbg_txn = t;
			dbg_req = 1'b1;
		end else begin
			host_txn = t;
			host_req = 1'b1;
		end
		while (!(port ? dbg_ack : host_ack)) begin
			@(posedge clk);
			#2;
		end
		ack_cyc = cycle;
		rdata = port ? dbg_rdata : host_rdata;
		repeat (hold) begin
			@(posedge clk);
			#2;
		end
		drop_cyc = cycle;
		if (port)
			dbg_req = 1'b0;
		else
			host_req = 1'b0;
		// Next req only after ack is low
		while (port ? dbg_ack : host_ack) begin
			@(posedge clk);
			#2;
		end
	endtask

	initial begin
		lb_data_t got;
		lb_data_t h_got;
		lb_data_t d_got;
		int h_ack;
		int d_ack;
		int h_drop;
		int d_drop;
		int n_faults;
		logic [7:0] duty1;
		logic [7:0] duty2;
		int on1;
		int on2;
		rst_n = 1'b0;
		host_req = 1'b0;
		host_txn = '0;
		dbg_req = 1'b0;
		dbg_txn = '0;
		xdomain_fault = 1'b0;
		f_run = 1'b0;
		lfsr_state = 8'd37;
		fill_table();
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		for (int r = 0; r < TABLE_ROWS; r++) begin
			bus_access(table_rows[r].port, table_rows[r].rd, table_rows[r].addr,
				table_rows[r].wdata, 0, got, h_ack, h_drop);
			if (table_rows[r].rd)
				check_word($sformatf("table row %0d", r), got, table_rows[r].exp);
		end
		check_word("led_user_mode", 32'(led_user_mode), 32'h1);
		// Only bit 0 counts
		bus_access(1'b0, 1'b0, reg_addr(BANK_REGS, OFS_LED_USER), 32'h2, 0, got, h_ack, h_drop);
		check_word("led_user_mode", 32'(led_user_mode), 32'h0);

		// Fault pulses, one clk cycle each with a gap
		n_faults = int'(take_bits(5)) + 1;
		repeat (n_faults) begin
			@(posedge clk);
			#2;
			xdomain_fault = 1'b1;
			@(posedge clk);
			#2;
			xdomain_fault = 1'b0;
		end
		bus_access(1'b1, 1'b1, reg_addr(BANK_REGS, OFS_FAULTS), '0, 0, got, h_ack, h_drop);
		check_word("fault count", got, 32'(n_faults));

		// PWM over one full counter period
		duty1 = take_bits(8);
		duty2 = take_bits(8);
		bus_access(1'b0, 1'b0, reg_addr(BANK_REGS, OFS_LED1_DUTY), 32'(duty1), 0,
			got, h_ack, h_drop);
		bus_access(1'b1, 1'b0, reg_addr(BANK_REGS, OFS_LED2_DUTY), 32'(duty2), 0,
			got, h_ack, h_drop);
		on1 = 0;
		on2 = 0;
		repeat (PWM_PERIOD) begin
			@(posedge clk);
			#2;
			on1 += int'(led1);
			on2 += int'(led2);
		end
		check_word("led1 on cycles", 32'(on1), 32'(int'(duty1) * 4));
		check_word("led2 on cycles", 32'(on2), 32'(int'(duty2) * 4));

		// At least one full window after two
		f_run = 1'b1;
		repeat (2 * WINDOW + 8) @(posedge clk);
		bus_access(1'b0, 1'b1, reg_addr(BANK_REGS, OFS_FREQ), '0, 0, got, h_ack, h_drop);
		checks++;
		assert (got >= 32'(FREQ_EXP - 1) && got <= 32'(FREQ_EXP + 1)) else begin
			errors++;
			$display("Error at %0d ns: frequency is %0d, expected %0d +/- 1",
				$time, got, FREQ_EXP);
		end

		// Host grant, then a tie goes to debug
		bus_access(1'b0, 1'b1, reg_addr(BANK_REGS, OFS_ID0), '0, 0, got, h_ack, h_drop);
		check_word("host ID0", got, ID_WORD0);
		fork
			bus_access(1'b0, 1'b1, reg_addr(BANK_REGS, OFS_ID2), '0, 0, h_got, h_ack, h_drop);
			bus_access(1'b1, 1'b1, reg_addr(BANK_REGS, OFS_ID3), '0, 0, d_got, d_ack, d_drop);
		join
		check_word("tied host read", h_got, ID_WORD2);
		check_word("tied debug read", d_got, ID_WORD3);
		check_order("debug ack before host ack", d_ack, h_ack);

		// Host parks on ack, debug must wait for its req to fall
		fork
			bus_access(1'b0, 1'b0, reg_addr(BANK_REGS, OFS_LED_USER), 32'h1, 10,
				h_got, h_ack, h_drop);
			begin
				repeat (2) @(posedge clk);
				bus_access(1'b1, 1'b1, reg_addr(BANK_REGS, OFS_ID1), '0, 0,
					d_got, d_ack, d_drop);
			end
		join
		check_word("blocked debug read", d_got, ID_WORD1);
		check_order("host req release before debug ack", h_drop, d_ack);

		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verification/lb_arbiter_sva.sv
// Concurrent checks on the arbiter handshake and slave strobe
// Bound into every lb_arbiter instance, see the bind at the bottom
`timescale 1ns/1ps

module lb_arbiter_sva (
	input logic clk,
	input logic rst_n,
	input logic host_req,
	input logic dbg_req,
	input logic host_ack,
	input logic dbg_ack,
	input logic control_strobe,
	input logic control_rd
);

	// Ack is registered, so req is checked one edge back
	host_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(host_ack) |-> $past(host_req)) else $error("host_ack rose without host_req");
	dbg_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(dbg_ack) |-> $past(dbg_req)) else $error("dbg_ack rose without dbg_req");

	// One master at a time
	acks_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(host_ack && dbg_ack)) else $error("host_ack and dbg_ack high together");

	strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		control_strobe |=> !control_strobe) else $error("control_strobe held two cycles");

	// Read ack set two edges after the strobe edge
	read_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
		control_strobe && control_rd |-> ##2 !(host_ack || dbg_ack) ##1 (host_ack || dbg_ack))
		else $error("read ack not two cycles after strobe");

endmodule

bind lb_arbiter lb_arbiter_sva u_sva (
	.clk(clk), .rst_n(rst_n),
	.host_req(host_req), .dbg_req(dbg_req),
	.host_ack(host_ack), .dbg_ack(dbg_ack),
	.control_strobe(control_strobe), .control_rd(control_rd)
);

//--- verilog/lb_demo_top.sv
// Top of the demo register block
// Host and debug masters share the slave through the arbiter
// Frequency window width is set here and passed to the counter
`timescale 1ns/1ps

module lb_demo_top #(
	parameter int REFCNT_WIDTH = 27,
	parameter int FREQ_WIDTH   = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              host_req,
	input  lb_pkg::lb_req_t   host_txn,
	output logic              host_ack,
	output lb_pkg::lb_data_t  host_rdata,
	input  logic              dbg_req,
	input  lb_pkg::lb_req_t   dbg_txn,
	output logic              dbg_ack,
	output lb_pkg::lb_data_t  dbg_rdata,
	input  logic              f_in,
	input  logic              xdomain_fault,
	output logic              led_user_mode,
	output logic              led1,
	output logic              led2
);
	import lb_pkg::*;

	// Arbiter to slave strobe bus
	lb_addr_t addr;
	logic control_strobe;
	logic control_rd;
	lb_data_t data_out;
	lb_data_t data_in;
	// Measured f_in rate
	logic [FREQ_WIDTH-1:0] frequency;

	lb_arbiter u_arbiter (
		.clk(clk), .rst_n(rst_n),
		.host_req(host_req), .host_txn(host_txn),
		.host_ack(host_ack), .host_rdata(host_rdata),
		.dbg_req(dbg_req), .dbg_txn(dbg_txn),
		.dbg_ack(dbg_ack), .dbg_rdata(dbg_rdata),
		.addr(addr), .control_strobe(control_strobe), .control_rd(control_rd),
		.data_out(data_out), .data_in(data_in)
	);

	lb_demo_slave u_slave (
		.clk(clk), .rst_n(rst_n),
		.addr(addr), .control_strobe(control_strobe), .control_rd(control_rd),
		.data_out(data_out), .data_in(data_in),
		.frequency(frequency), .xdomain_fault(xdomain_fault),
		.led_user_mode(led_user_mode), .led1(led1), .led2(led2)
	);

	freq_count #(
		.REFCNT_WIDTH(REFCNT_WIDTH),
		.FREQ_WIDTH(FREQ_WIDTH)
	) u_freq (
		.clk(clk), .rst_n(rst_n), .f_in(f_in), .frequency(frequency)
	);

endmodule

//--- verilog/lb_demo_slave.sv
// Demo local bus slave for bring-up, proves the bus master is alive
// Reads return ID text, a fault count and a measured frequency
// Writes drive a user LED and two PWM-dimmed LEDs
`timescale 1ns/1ps

module lb_demo_slave (
	input  logic              clk,
	input  logic              rst_n,
	input  lb_pkg::lb_addr_t  addr,
	input  logic              control_strobe,
	input  logic              control_rd,
	input  lb_pkg::lb_data_t  data_out,
	output lb_pkg::lb_data_t  data_in,
	input  logic [31:0]       frequency,
	input  logic              xdomain_fault,
	output logic              led_user_mode,
	output logic              led1,
	output logic              led2
);
	import lb_pkg::*;
	import demo_regs_pkg::*;

	logic do_rd;
	logic do_wr;
	logic [15:0] fault_cnt;
	logic do_rd_r;
	logic [7:0] bank_r;
	lb_data_t reg_bank_0;
	logic led_user_r;
	logic [DUTY_WIDTH-1:0] led1_duty;
	logic [DUTY_WIDTH-1:0] led2_duty;
	logic [PWM_CNT_WIDTH-1:0] pwm_cnt;

	assign do_rd = control_strobe & control_rd;
	assign do_wr = control_strobe & ~control_rd;

	// Cross-domain fault pulses, already in clk domain
	// Wraps silently, a burst at power-up is expected
	always_ff @(posedge clk) begin
		if (!rst_n)
			fault_cnt <= '0;
		else if (xdomain_fault)
			fault_cnt <= fault_cnt + 1'b1;
	end

	// Read stage 1, offset decode inside the register bank
	always_ff @(posedge clk) begin
		if (!rst_n)
			do_rd_r <= 1'b0;
		else
			do_rd_r <= do_rd;
	end

	always_ff @(posedge clk) begin
		bank_r <= addr[23:16];
		if (do_rd) begin
			case (addr[3:0])
				OFS_ID0: reg_bank_0 <= ID_WORD0;
				OFS_ID1: reg_bank_0 <= ID_WORD1;
				OFS_ID2: reg_bank_0 <= ID_WORD2;
				OFS_ID3: reg_bank_0 <= ID_WORD3;
				OFS_FAULTS: reg_bank_0 <= {16'h0, fault_cnt};
				OFS_FREQ: reg_bank_0 <= frequency;
				default: reg_bank_0 <= UNUSED_OFS_WORD;
			endcase
		end
	end

	// Read stage 2, bank select on the delayed address
	always_ff @(posedge clk) begin
		if (do_rd_r) begin
			case (bank_r)
				BANK_BADGE_IN,
				BANK_BADGE_OUT: data_in <= BADGE_WORD;
				BANK_REGS: data_in <= reg_bank_0;
				default: data_in <= UNMAPPED_WORD;
			endcase
		end
	end

	// Writes decode the offset only, bank ignored
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_user_r <= 1'b0;
			led1_duty <= '0;
			led2_duty <= '0;
		end else if (do_wr) begin
			case (addr[3:0])
				OFS_LED_USER: led_user_r <= data_out[0];
				OFS_LED1_DUTY: led1_duty <= data_out[DUTY_WIDTH-1:0];
				OFS_LED2_DUTY: led2_duty <= data_out[DUTY_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	// PWM: LED on while count < duty*4, period 1024 cycles
	// Fast enough that the eye sees only brightness
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pwm_cnt <= '0;
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			led1 <= pwm_cnt < {led1_duty, 2'b00};
			led2 <= pwm_cnt < {led2_duty, 2'b00};
		end
	end

	assign led_user_mode = led_user_r;

endmodule

//--- verilog/lb_arbiter.sv
// Two-port round-robin arbiter in front of the local bus slave
// Each master port runs a four-phase req/ack handshake
// The slave side gets one single-cycle strobe per access
`timescale 1ns/1ps

module lb_arbiter (
	input  logic              clk,
	input  logic              rst_n,
	// Host master port
	input  logic              host_req,
	input  lb_pkg::lb_req_t   host_txn,
	output logic              host_ack,
	output lb_pkg::lb_data_t  host_rdata,
	// Debug master port
	input  logic              dbg_req,
	input  lb_pkg::lb_req_t   dbg_txn,
	output logic              dbg_ack,
	output lb_pkg::lb_data_t  dbg_rdata,
	// Slave side
	output lb_pkg::lb_addr_t  addr,
	output logic              control_strobe,
	output logic              control_rd,
	output lb_pkg::lb_data_t  data_out,
	input  lb_pkg::lb_data_t  data_in
);
	import lb_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_STROBE,
		S_WAIT,    // Counting down the slave read latency
		S_HOLD     // Ack high until the master drops req
	} state_t;

	// Slave read pipeline depth after the strobe edge
	localparam int RD_LATENCY = 2;

	state_t state;
	lb_req_t txn_q;
	logic grant_dbg;
	logic last_dbg;
	logic [1:0] wait_cnt;
	logic pick_dbg;
	logic granted_req;
	logic done;

	// Debug wins a tie only when host was served last
	assign pick_dbg = dbg_req & (~host_req | ~last_dbg);
	assign granted_req = grant_dbg ? dbg_req : host_req;
	assign done = (state == S_WAIT) && (wait_cnt == 2'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			last_dbg <= 1'b1;  // Host first out of reset
			grant_dbg <= 1'b0;
			wait_cnt <= 2'd0;
			host_ack <= 1'b0;
			dbg_ack <= 1'b0;
		end else begin
			case (state)
				S_IDLE: if (host_req | dbg_req) begin
					grant_dbg <= pick_dbg;
					last_dbg <= pick_dbg;
					state <= S_STROBE;
				end
				S_STROBE: begin
					// Writes complete one edge after the strobe
					wait_cnt <= txn_q.rd ? 2'(RD_LATENCY - 1) : 2'd0;
					state <= S_WAIT;
				end
				S_WAIT: if (done) begin
					host_ack <= ~grant_dbg;
					dbg_ack <= grant_dbg;
					state <= S_HOLD;
				end else begin
					wait_cnt <= wait_cnt - 1'b1;
				end
				S_HOLD: if (!granted_req) begin
					host_ack <= 1'b0;
					dbg_ack <= 1'b0;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Winning transaction and read return data
	always_ff @(posedge clk) begin
		if (state == S_IDLE && (host_req | dbg_req))
			txn_q <= pick_dbg ? dbg_txn : host_txn;
		if (done && txn_q.rd) begin
			if (grant_dbg)
				dbg_rdata <= data_in;
			else
				host_rdata <= data_in;
		end
	end

	assign control_strobe = (state == S_STROBE);
	assign control_rd = txn_q.rd;
	assign addr = txn_q.addr;
	assign data_out = txn_q.wdata;

endmodule

//--- verilog/freq_count.sv
// Measures the rate of an external clock in units of edges per window
// The window is 2^REFCNT_WIDTH cycles of clk, result refreshed each window
`timescale 1ns/1ps

module freq_count #(
	parameter int REFCNT_WIDTH = 27,
	parameter int FREQ_WIDTH   = 32
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  f_in,
	output logic [FREQ_WIDTH-1:0] frequency
);

	logic [1:0] f_sync;
	logic f_last;
	logic f_rise;
	logic [REFCNT_WIDTH-1:0] ref_cnt;
	logic [FREQ_WIDTH-1:0] edge_cnt;
	logic window_end;

	// Two-flop synchronizer, then one more stage for edge detect
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			f_sync <= 2'b00;
			f_last <= 1'b0;
		end else begin
			f_sync <= {f_sync[0], f_in};
			f_last <= f_sync[1];
		end
	end

	assign f_rise = f_sync[1] & ~f_last;

	// Last cycle of the reference window
	assign window_end = &ref_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ref_cnt <= '0;
			edge_cnt <= '0;
			frequency <= '0;
		end else begin
			ref_cnt <= ref_cnt + 1'b1;
			if (window_end) begin
				// Include an edge landing on the final cycle
				frequency <= edge_cnt + FREQ_WIDTH'(f_rise);
				edge_cnt <= '0;
			end else if (f_rise) begin
				edge_cnt <= edge_cnt + 1'b1;
			end
		end
	end

endmodule

//--- verilog/demo_regs_pkg.sv
// Register map of the demo slave
// Bank codes live in the address top byte, offsets in the low nibble
// Used by the slave and by the testbench for expected values
`ifndef DEMO_REGS_PKG_SV
`define DEMO_REGS_PKG_SV

package demo_regs_pkg;

	// Bank codes, address bits 23:16
	localparam logic [7:0] BANK_BADGE_IN  = 8'h01;
	localparam logic [7:0] BANK_BADGE_OUT = 8'h02;
	localparam logic [7:0] BANK_REGS      = 8'h11;

	// Read offsets in BANK_REGS
	localparam logic [3:0] OFS_ID0    = 4'd0;
	localparam logic [3:0] OFS_ID1    = 4'd1;
	localparam logic [3:0] OFS_ID2    = 4'd2;
	localparam logic [3:0] OFS_ID3    = 4'd3;
	localparam logic [3:0] OFS_FAULTS = 4'd4;
	localparam logic [3:0] OFS_FREQ   = 4'd5;

	// Write offsets, any bank
	localparam logic [3:0] OFS_LED_USER  = 4'd1;
	localparam logic [3:0] OFS_LED1_DUTY = 4'd2;
	localparam logic [3:0] OFS_LED2_DUTY = 4'd3;

	// Fixed read words, ASCII packed big-endian
	localparam logic [31:0] ID_WORD0        = "Hell";
	localparam logic [31:0] ID_WORD1        = "o wo";
	localparam logic [31:0] ID_WORD2        = "rld!";
	localparam logic [31:0] ID_WORD3        = "(::)";
	localparam logic [31:0] UNUSED_OFS_WORD = "zzzz";
	localparam logic [31:0] BADGE_WORD      = 32'h0;  // Badge trace not built
	localparam logic [31:0] UNMAPPED_WORD   = 32'hdeadbeef;

	// PWM counter and duty factor widths
	localparam int PWM_CNT_WIDTH = 10;
	localparam int DUTY_WIDTH    = 8;

endpackage

`endif

//--- verilog/lb_pkg.sv
// Local bus transaction types
// Shared by the arbiter, the top level and the testbench
// Masters hand one lb_req_t per access to the arbiter
`ifndef LB_PKG_SV
`define LB_PKG_SV

package lb_pkg;

	// 24-bit local bus address, top byte selects the bank
	typedef logic [23:0] lb_addr_t;

	// One data word, both directions
	typedef logic [31:0] lb_data_t;

	// A single bus request as driven by a master
	// Must stay stable while req is high
	typedef struct packed {
		logic     rd;     // 1 = read, 0 = write
		lb_addr_t addr;
		lb_data_t wdata;  // Ignored on reads
	} lb_req_t;

endpackage

`endif
